//--- Bender.yml
package:
  name: uart_top

sources:
  - uart_pkg.sv
  - uart_if.sv
  - uart_tx.sv
  - uart_rx.sv
  - uart_core.sv
  - uart_regs.sv
  - uart_top.sv
  - target: simulation
    files:
      - uart_tb.sv

//--- uart_core.sv
`timescale 1ns/1ns
`default_nettype none

module uart_core (
    input  logic       clk,
    input  logic       rst,
    uart_cfg_if.core   cfg,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    input  logic       data_read,
    output logic [7:0] rx_data,
    output logic       tx_busy,
    output logic       rx_valid,
    output logic       err_framing,
    output logic       err_parity,
    output logic       ser_tx,
    input  logic       ser_rx
);

    uart_rx_if rx_if ();

    logic [uart_pkg::DATA_BITS-1:0] rx_buf;
    logic                           frame_ok;

    uart_tx u_tx (
        .clk    (clk),
        .rst    (rst),
        .cfg    (cfg),
        .start  (tx_start),
        .data   (tx_data),
        .busy   (tx_busy),
        .ser_tx (ser_tx)
    );

    uart_rx u_rx (
        .clk    (clk),
        .rst    (rst),
        .cfg    (cfg),
        .ser_rx (ser_rx),
        .rx     (rx_if)
    );

    assign frame_ok = rx_if.frame_done && !rx_if.framing_err;

    // New frame overwrites an unread byte
    always_ff @(posedge clk) begin
        if (frame_ok)
            rx_buf <= rx_if.rx_byte;
    end

    assign rx_data = rx_buf;

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_valid    <= 1'b0;
            err_framing <= 1'b0;
            err_parity  <= 1'b0;
        end else begin
            if (data_read)
                rx_valid <= 1'b0;
            if (frame_ok)
                rx_valid <= 1'b1; // New byte wins over a read in the same cycle
            if (rx_if.frame_done) begin
                err_framing <= rx_if.framing_err;
                err_parity  <= rx_if.parity_err;
            end
        end
    end

endmodule

`default_nettype wire

//--- uart_if.sv
`timescale 1ns/1ns
`default_nettype none

// Line settings shared by transmitter and receiver
interface uart_cfg_if;

    logic [uart_pkg::DIV_W-1:0] divisor; // Bit period minus one
    logic                       tx_en;
    logic                       rx_en;
    logic                       parity_en;
    logic                       even_parity;
    logic                       dual_stop;

    modport regs (
        output divisor,
        output tx_en,
        output rx_en,
        output parity_en,
        output even_parity,
        output dual_stop
    );

    modport core (
        input divisor,
        input tx_en,
        input rx_en,
        input parity_en,
        input even_parity,
        input dual_stop
    );

endinterface

// Result of one received frame
interface uart_rx_if;

    logic       frame_done; // Single cycle pulse
    logic [7:0] rx_byte;
    logic       parity_err;
    logic       framing_err;

    modport rx   (output frame_done, output rx_byte, output parity_err, output framing_err);
    modport core (input frame_done, input rx_byte, input parity_err, input framing_err);

endinterface

`default_nettype wire

//--- uart_pkg.sv
`default_nettype none

package uart_pkg;

    //////////////////////////////////////////////////
    // Register map
    localparam logic [1:0] ADDR_DATA    = 2'd0;
    localparam logic [1:0] ADDR_DIVISOR = 2'd1;
    localparam logic [1:0] ADDR_CTRL    = 2'd2;
    localparam logic [1:0] ADDR_STATUS  = 2'd3;

    // Control register bits
    localparam int CTRL_TX_EN       = 0;
    localparam int CTRL_RX_EN       = 1;
    localparam int CTRL_PARITY_EN   = 2;
    localparam int CTRL_EVEN_PARITY = 3;
    localparam int CTRL_DUAL_STOP   = 4;

    // Status register bits (read only)
    localparam int STAT_TX_EMPTY    = 0;
    localparam int STAT_RX_VALID    = 1;
    localparam int STAT_FRAMING_ERR = 2;
    localparam int STAT_PARITY_ERR  = 3;

    //////////////////////////////////////////////////
    // Frame and bus widths
    localparam int DATA_BITS = 8;  // Data bits per frame
    localparam int DIV_W     = 32; // Bit period divisor
    localparam int BUS_W     = 32;

endpackage

`default_nettype wire

//--- uart_regs.sv
`timescale 1ns/1ns
`default_nettype none

module uart_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [1:0]                 bus_addr,
    input  logic                       bus_wr,
    input  logic                       bus_rd,
    input  logic [uart_pkg::BUS_W-1:0] bus_wdata,
    output logic [uart_pkg::BUS_W-1:0] bus_rdata,
    uart_cfg_if.regs                   cfg,
    output logic                       tx_start,
    output logic [7:0]                 tx_data,
    output logic                       data_read,
    input  logic [7:0]                 rx_data,
    input  logic                       tx_busy,
    input  logic                       rx_valid,
    input  logic                       err_framing,
    input  logic                       err_parity
);

    logic [uart_pkg::DIV_W-1:0]        divisor_q;
    logic [uart_pkg::CTRL_DUAL_STOP:0] ctrl_q;
    logic [uart_pkg::BUS_W-1:0]        rd_word;

    //////////////////////////////////////////////////
    // Writable registers
    always_ff @(posedge clk) begin
        if (rst) begin
            divisor_q <= '0;
            ctrl_q    <= '0;
        end else if (bus_wr) begin
            case (bus_addr)
                uart_pkg::ADDR_DIVISOR: divisor_q <= bus_wdata[uart_pkg::DIV_W-1:0];
                uart_pkg::ADDR_CTRL:    ctrl_q    <= bus_wdata[uart_pkg::CTRL_DUAL_STOP:0];
                default: ;
            endcase
        end
    end

    assign cfg.divisor     = divisor_q;
    assign cfg.tx_en       = ctrl_q[uart_pkg::CTRL_TX_EN];
    assign cfg.rx_en       = ctrl_q[uart_pkg::CTRL_RX_EN];
    assign cfg.parity_en   = ctrl_q[uart_pkg::CTRL_PARITY_EN];
    assign cfg.even_parity = ctrl_q[uart_pkg::CTRL_EVEN_PARITY];
    assign cfg.dual_stop   = ctrl_q[uart_pkg::CTRL_DUAL_STOP];

    // Data register strobes
    assign tx_start  = bus_wr && (bus_addr == uart_pkg::ADDR_DATA);
    assign tx_data   = bus_wdata[7:0];
    assign data_read = bus_rd && (bus_addr == uart_pkg::ADDR_DATA);

    //////////////////////////////////////////////////
    // Read mux
    always_comb begin
        rd_word = '0;
        case (bus_addr)
            uart_pkg::ADDR_DATA:    rd_word[7:0] = rx_data;
            uart_pkg::ADDR_DIVISOR: rd_word[uart_pkg::DIV_W-1:0] = divisor_q;
            uart_pkg::ADDR_CTRL:    rd_word[uart_pkg::CTRL_DUAL_STOP:0] = ctrl_q;
            default: begin
                rd_word[uart_pkg::STAT_TX_EMPTY]    = ~tx_busy;
                rd_word[uart_pkg::STAT_RX_VALID]    = rx_valid;
                rd_word[uart_pkg::STAT_FRAMING_ERR] = err_framing;
                rd_word[uart_pkg::STAT_PARITY_ERR]  = err_parity;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            bus_rdata <= '0;
        else if (bus_rd)
            bus_rdata <= rd_word; // Held until the next read
    end

endmodule

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  logic     clk,
    input  logic     rst,
    uart_cfg_if.core cfg,
    input  logic     ser_rx,
    uart_rx_if.rx    rx
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_PARITY,
        S_STOP
    } rx_state_t;

    rx_state_t                              state;
    logic [2:0]                             line_q; // Two sync flops plus edge history
    logic                                   rx_s;
    logic                                   rx_fall;
    logic                                   sample;
    logic [uart_pkg::DIV_W-1:0]             div_cnt;
    logic [$clog2(uart_pkg::DATA_BITS)-1:0] bit_cnt;
    logic                                   second_stop;
    logic [uart_pkg::DATA_BITS-1:0]         shift_q;
    logic                                   perr_q;
    logic                                   ferr_q;
    logic                                   done_q;

    //////////////////////////////////////////////////
    // Input synchronizer and start edge
    always_ff @(posedge clk) begin
        if (rst)
            line_q <= '1; // Idle line is high
        else
            line_q <= {line_q[1:0], ser_rx};
    end

    assign rx_s    = line_q[1];
    assign rx_fall = line_q[2] & ~line_q[1];

    // Start bit checked at half period and the rest one full period apart
    assign sample = (state == S_START) ? (div_cnt == (cfg.divisor >> 1))
                                       : (div_cnt == cfg.divisor);

    always_ff @(posedge clk) begin
        if (state == S_DATA && sample)
            shift_q <= {rx_s, shift_q[uart_pkg::DATA_BITS-1:1]};
    end

    //////////////////////////////////////////////////
    // Frame FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_IDLE;
            div_cnt     <= '0;
            bit_cnt     <= '0;
            second_stop <= 1'b0;
            perr_q      <= 1'b0;
            ferr_q      <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (state == S_IDLE) begin
                div_cnt <= '0;
                if (cfg.rx_en && rx_fall)
                    state <= S_START;
            end else if (!sample) begin
                div_cnt <= div_cnt + 1'b1;
            end else begin
                div_cnt <= '0;
                case (state)
                    S_START: begin
                        if (rx_s) begin
                            state <= S_IDLE; // Glitch rather than a start bit
                        end else begin
                            bit_cnt     <= '0;
                            second_stop <= 1'b0;
                            perr_q      <= 1'b0;
                            ferr_q      <= 1'b0;
                            state       <= S_DATA;
                        end
                    end
                    S_DATA: begin
                        if (int'(bit_cnt) == uart_pkg::DATA_BITS - 1)
                            state <= cfg.parity_en ? S_PARITY : S_STOP;
                        else
                            bit_cnt <= bit_cnt + 1'b1;
                    end
                    S_PARITY: begin
                        perr_q <= (rx_s != (^shift_q ^ ~cfg.even_parity));
                        state  <= S_STOP;
                    end
                    S_STOP: begin
                        ferr_q <= ferr_q | ~rx_s; // Any low stop bit
                        if (cfg.dual_stop && !second_stop) begin
                            second_stop <= 1'b1;
                        end else begin
                            done_q <= 1'b1;
                            state  <= S_IDLE;
                        end
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    assign rx.frame_done  = done_q;
    assign rx.rx_byte     = shift_q;
    assign rx.parity_err  = perr_q;
    assign rx.framing_err = ferr_q;

endmodule

`default_nettype wire

//--- uart_tb.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tb;

    localparam int DIVISOR    = 7;
    localparam int BIT_CYCLES = DIVISOR + 1;
    localparam int HALF_BIT   = BIT_CYCLES / 2;
    localparam int MAX_TRIES  = 500; // Status polls before giving up

    logic        clk;
    logic        rst;
    logic [1:0]  bus_addr;
    logic        bus_wr;
    logic        bus_rd;
    logic [31:0] bus_wdata;
    logic [31:0] bus_rdata;
    logic        ser_tx;
    logic        ser_rx;
    logic        loop_en;  // Loopback when high
    logic        drv_line; // Serial driver output
    integer      seed;

    uart_top u_uart_top (
        .clk       (clk),
        .rst       (rst),
        .bus_addr  (bus_addr),
        .bus_wr    (bus_wr),
        .bus_rd    (bus_rd),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .ser_tx    (ser_tx),
        .ser_rx    (ser_rx)
    );

    assign ser_rx = loop_en ? ser_tx : drv_line;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Checks and bus access
    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAIL %s expected %0h actual %0h", name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic timed_out(input string what);
        $display("Timed out while waiting for %s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "Wait timed out");
    endtask

    task automatic bus_write(input logic [1:0] addr, input logic [31:0] data);
        @(negedge clk);
        bus_addr  = addr;
        bus_wdata = data;
        bus_wr    = 1'b1;
        @(negedge clk);
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input logic [1:0] addr, output logic [31:0] data);
        @(negedge clk);
        bus_addr = addr;
        bus_rd   = 1'b1;
        @(negedge clk);
        bus_rd = 1'b0;
        data   = bus_rdata; // Registered so stable here
    endtask

    task automatic wait_status(input int bit_idx, input logic value, input string what);
        logic [31:0] st;
        int          tries;
        tries = 0;
        bus_read(uart_pkg::ADDR_STATUS, st);
        while (st[bit_idx] !== value && tries < MAX_TRIES) begin
            tries++;
            bus_read(uart_pkg::ADDR_STATUS, st);
        end
        if (st[bit_idx] !== value)
            timed_out(what);
    endtask

    //////////////////////////////////////////////////
    // Serial side
    task automatic check_tx_frame(input logic [7:0] data, input logic [4:0] ctrl,
                                  input logic busy_write, input string name);
        logic        exp_q[$];
        logic [31:0] st;
        int          cnt;
        exp_q.push_back(1'b0); // Start
        for (int i = 0; i < 8; i++)
            exp_q.push_back(data[i]);
        if (ctrl[uart_pkg::CTRL_PARITY_EN])
            exp_q.push_back(ctrl[uart_pkg::CTRL_EVEN_PARITY] ? ^data : ~^data);
        exp_q.push_back(1'b1);
        if (ctrl[uart_pkg::CTRL_DUAL_STOP])
            exp_q.push_back(1'b1);
        bus_write(uart_pkg::ADDR_DATA, {24'd0, data});
        cnt = 0;
        while (ser_tx === 1'b1 && cnt < 4 * BIT_CYCLES) begin
            @(negedge clk);
            cnt++;
        end
        if (ser_tx !== 1'b0)
            timed_out("start bit on ser_tx");
        if (busy_write) begin
            // Four negedges in total like the plain half-bit wait
            bus_read(uart_pkg::ADDR_STATUS, st);
            check_eq({name, " tx_empty during frame"}, 0, st[uart_pkg::STAT_TX_EMPTY]);
            bus_write(uart_pkg::ADDR_DATA, {24'd0, ~data});
        end else begin
            repeat (HALF_BIT) @(negedge clk);
        end
        foreach (exp_q[i]) begin
            if (i > 0)
                repeat (BIT_CYCLES) @(negedge clk);
            check_eq($sformatf("%s bit %0d", name, i), exp_q[i], ser_tx);
        end
        wait_status(uart_pkg::STAT_TX_EMPTY, 1'b1, "tx_empty after frame");
        repeat (3 * BIT_CYCLES) begin
            @(negedge clk);
            check_eq({name, " idle after frame"}, 1, ser_tx); // No second frame
        end
    endtask

    task automatic drive_frame(input logic [7:0] data, input logic par_en, input logic par_bit,
                               input logic stop_bit, input logic dual);
        @(negedge clk);
        drv_line = 1'b0;
        repeat (BIT_CYCLES) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            drv_line = data[i];
            repeat (BIT_CYCLES) @(negedge clk);
        end
        if (par_en) begin
            drv_line = par_bit;
            repeat (BIT_CYCLES) @(negedge clk);
        end
        drv_line = stop_bit;
        repeat (BIT_CYCLES) @(negedge clk);
        if (dual) begin
            drv_line = 1'b1;
            repeat (BIT_CYCLES) @(negedge clk);
        end
        drv_line = 1'b1;
        repeat (BIT_CYCLES) @(negedge clk); // Idle gap
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    initial begin : main
        logic [31:0] rd;
        logic [7:0]  b;
        logic [4:0]  ctrl;
        seed      = 32'h4d08;
        rst       = 1'b1;
        bus_addr  = '0;
        bus_wr    = 1'b0;
        bus_rd    = 1'b0;
        bus_wdata = '0;
        loop_en   = 1'b0;
        drv_line  = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // Reset values and register read back
        bus_read(uart_pkg::ADDR_STATUS, rd);
        check_eq("reset status", 32'd1 << uart_pkg::STAT_TX_EMPTY, rd);
        check_eq("reset ser_tx", 1, ser_tx);
        bus_read(uart_pkg::ADDR_DIVISOR, rd);
        check_eq("reset divisor", 0, rd);
        bus_read(uart_pkg::ADDR_CTRL, rd);
        check_eq("reset ctrl", 0, rd);
        bus_write(uart_pkg::ADDR_DIVISOR, 32'h0012_3456);
        bus_read(uart_pkg::ADDR_DIVISOR, rd);
        check_eq("divisor readback", 32'h0012_3456, rd);
        bus_write(uart_pkg::ADDR_DIVISOR, DIVISOR);
        bus_read(uart_pkg::ADDR_DIVISOR, rd);
        check_eq("divisor readback", DIVISOR, rd);
        bus_write(uart_pkg::ADDR_CTRL, 32'h1f);
        bus_read(uart_pkg::ADDR_CTRL, rd);
        check_eq("ctrl readback", 32'h1f, rd);

        // Loopback in 8N1
        loop_en = 1'b1;
        ctrl    = '0;
        ctrl[uart_pkg::CTRL_TX_EN] = 1'b1;
        ctrl[uart_pkg::CTRL_RX_EN] = 1'b1;
        bus_write(uart_pkg::ADDR_CTRL, {27'd0, ctrl});
        repeat (16) begin
            b = $random(seed);
            bus_write(uart_pkg::ADDR_DATA, {24'd0, b});
            wait_status(uart_pkg::STAT_RX_VALID, 1'b1, "rx_valid in loopback");
            bus_read(uart_pkg::ADDR_DATA, rd);
            check_eq("loopback data", b, rd);
            bus_read(uart_pkg::ADDR_STATUS, rd);
            check_eq("loopback rx_valid cleared", 0, rd[uart_pkg::STAT_RX_VALID]);
            check_eq("loopback framing_err", 0, rd[uart_pkg::STAT_FRAMING_ERR]);
            check_eq("loopback parity_err", 0, rd[uart_pkg::STAT_PARITY_ERR]);
            wait_status(uart_pkg::STAT_TX_EMPTY, 1'b1, "tx_empty in loopback");
        end
        loop_en = 1'b0;

        // Transmit frame shape for every parity and stop mix
        for (int c = 0; c < 8; c++) begin
            ctrl = '0;
            ctrl[uart_pkg::CTRL_TX_EN]       = 1'b1;
            ctrl[uart_pkg::CTRL_PARITY_EN]   = c[0];
            ctrl[uart_pkg::CTRL_EVEN_PARITY] = c[1];
            ctrl[uart_pkg::CTRL_DUAL_STOP]   = c[2];
            bus_write(uart_pkg::ADDR_CTRL, {27'd0, ctrl});
            b = $random(seed);
            check_tx_frame(b, ctrl, 1'b0, $sformatf("tx frame cfg %0d", c));
        end
        b = $random(seed);
        check_tx_frame(b, ctrl, 1'b1, "tx write while busy");

        // Parity error and then a clean frame clears it
        ctrl = '0;
        ctrl[uart_pkg::CTRL_RX_EN]       = 1'b1;
        ctrl[uart_pkg::CTRL_PARITY_EN]   = 1'b1;
        ctrl[uart_pkg::CTRL_EVEN_PARITY] = 1'b1;
        bus_write(uart_pkg::ADDR_CTRL, {27'd0, ctrl});
        b = $random(seed);
        drive_frame(b, 1'b1, ~^b, 1'b1, 1'b0);
        wait_status(uart_pkg::STAT_RX_VALID, 1'b1, "rx_valid after bad parity");
        bus_read(uart_pkg::ADDR_STATUS, rd);
        check_eq("bad parity parity_err", 1, rd[uart_pkg::STAT_PARITY_ERR]);
        check_eq("bad parity framing_err", 0, rd[uart_pkg::STAT_FRAMING_ERR]);
        bus_read(uart_pkg::ADDR_DATA, rd);
        check_eq("bad parity data", b, rd);
        b = $random(seed);
        drive_frame(b, 1'b1, ^b, 1'b1, 1'b0);
        wait_status(uart_pkg::STAT_RX_VALID, 1'b1, "rx_valid after good parity");
        bus_read(uart_pkg::ADDR_STATUS, rd);
        check_eq("good parity parity_err", 0, rd[uart_pkg::STAT_PARITY_ERR]);
        bus_read(uart_pkg::ADDR_DATA, rd);
        check_eq("good parity data", b, rd);

        // Framing error in 8N1
        ctrl = '0;
        ctrl[uart_pkg::CTRL_RX_EN] = 1'b1;
        bus_write(uart_pkg::ADDR_CTRL, {27'd0, ctrl});
        b = $random(seed);
        drive_frame(b, 1'b0, 1'b0, 1'b0, 1'b0);
        wait_status(uart_pkg::STAT_FRAMING_ERR, 1'b1, "framing_err");
        bus_read(uart_pkg::ADDR_STATUS, rd);
        check_eq("framing rx_valid", 0, rd[uart_pkg::STAT_RX_VALID]);
        drive_frame(b, 1'b0, 1'b0, 1'b1, 1'b0);
        wait_status(uart_pkg::STAT_RX_VALID, 1'b1, "rx_valid after clean frame");
        bus_read(uart_pkg::ADDR_STATUS, rd);
        check_eq("clean frame framing_err", 0, rd[uart_pkg::STAT_FRAMING_ERR]);
        bus_read(uart_pkg::ADDR_DATA, rd);
        check_eq("clean frame data", b, rd);

        // Receiver disabled ignores the line
        bus_write(uart_pkg::ADDR_CTRL, 32'd0);
        drive_frame(~b, 1'b0, 1'b0, 1'b0, 1'b0);
        repeat (2 * BIT_CYCLES) @(negedge clk);
        bus_read(uart_pkg::ADDR_STATUS, rd);
        check_eq("rx disabled status", 32'd1 << uart_pkg::STAT_TX_EMPTY, rd);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- uart_top.f
uart_pkg.sv
uart_if.sv
uart_tx.sv
uart_rx.sv
uart_core.sv
uart_regs.sv
uart_top.sv
uart_tb.sv

//--- uart_top.sv
`timescale 1ns/1ns
`default_nettype none

module uart_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [1:0]                 bus_addr,
    input  logic                       bus_wr,
    input  logic                       bus_rd,
    input  logic [uart_pkg::BUS_W-1:0] bus_wdata,
    output logic [uart_pkg::BUS_W-1:0] bus_rdata,
    output logic                       ser_tx,
    input  logic                       ser_rx
);

    uart_cfg_if cfg_if ();

    logic       tx_start;
    logic [7:0] tx_data;
    logic       data_read;
    logic [7:0] rx_data;
    logic       tx_busy;
    logic       rx_valid;
    logic       err_framing;
    logic       err_parity;

    uart_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .bus_addr    (bus_addr),
        .bus_wr      (bus_wr),
        .bus_rd      (bus_rd),
        .bus_wdata   (bus_wdata),
        .bus_rdata   (bus_rdata),
        .cfg         (cfg_if),
        .tx_start    (tx_start),
        .tx_data     (tx_data),
        .data_read   (data_read),
        .rx_data     (rx_data),
        .tx_busy     (tx_busy),
        .rx_valid    (rx_valid),
        .err_framing (err_framing),
        .err_parity  (err_parity)
    );

    uart_core u_core (
        .clk         (clk),
        .rst         (rst),
        .cfg         (cfg_if),
        .tx_start    (tx_start),
        .tx_data     (tx_data),
        .data_read   (data_read),
        .rx_data     (rx_data),
        .tx_busy     (tx_busy),
        .rx_valid    (rx_valid),
        .err_framing (err_framing),
        .err_parity  (err_parity),
        .ser_tx      (ser_tx),
        .ser_rx      (ser_rx)
    );

endmodule

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    uart_cfg_if.core   cfg,
    input  logic       start,
    input  logic [7:0] data,
    output logic       busy,
    output logic       ser_tx
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_PARITY,
        S_STOP
    } tx_state_t;

    tx_state_t                              state;
    logic [uart_pkg::DIV_W-1:0]             div_cnt;
    logic [$clog2(uart_pkg::DATA_BITS)-1:0] bit_cnt;
    logic                                   second_stop;
    logic [uart_pkg::DATA_BITS-1:0]         shift_q;
    logic                                   parity_q;
    logic                                   load;
    logic                                   bit_end;

    assign load    = (state == S_IDLE) && start && cfg.tx_en;
    assign bit_end = (state != S_IDLE) && (div_cnt == cfg.divisor);
    assign busy    = (state != S_IDLE);

    // Byte and its parity latched at start
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q  <= data;
            parity_q <= ^data ^ ~cfg.even_parity;
        end else if (bit_end && (state == S_START || state == S_DATA)) begin
            shift_q <= shift_q >> 1; // LSB first
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_IDLE;
            div_cnt     <= '0;
            bit_cnt     <= '0;
            second_stop <= 1'b0;
            ser_tx      <= 1'b1;
        end else if (load) begin
            state   <= S_START;
            div_cnt <= '0;
            ser_tx  <= 1'b0; // Start bit
        end else if (state != S_IDLE) begin
            if (!bit_end) begin
                div_cnt <= div_cnt + 1'b1;
            end else begin
                div_cnt <= '0;
                case (state)
                    S_START: begin
                        ser_tx  <= shift_q[0];
                        bit_cnt <= '0;
                        state   <= S_DATA;
                    end
                    S_DATA: begin
                        if (int'(bit_cnt) == uart_pkg::DATA_BITS - 1) begin
                            if (cfg.parity_en) begin
                                ser_tx <= parity_q;
                                state  <= S_PARITY;
                            end else begin
                                ser_tx      <= 1'b1;
                                second_stop <= 1'b0;
                                state       <= S_STOP;
                            end
                        end else begin
                            ser_tx  <= shift_q[0];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    S_PARITY: begin
                        ser_tx      <= 1'b1;
                        second_stop <= 1'b0;
                        state       <= S_STOP;
                    end
                    S_STOP: begin
                        if (cfg.dual_stop && !second_stop)
                            second_stop <= 1'b1;
                        else
                            state <= S_IDLE; // Line stays high
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire
